//--- verilog.f
+incdir+.
lq_pkg.sv
lq_issue_if.sv
lq_pointers.sv
lq_entry_table.sv
lq_violation_check.sv
load_queue.sv
tb_clock_gen.sv
load_queue_assert.sv
load_queue_tb.sv

//--- Bender.yml
package:
  name: load_queue

export_include_dirs:
  - .

sources:
  - files:
      - lq_pkg.sv
      - lq_issue_if.sv
      - lq_pointers.sv
      - lq_entry_table.sv
      - lq_violation_check.sv
      - load_queue.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - load_queue_assert.sv
      - load_queue_tb.sv

//--- load_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lq_config.svh"

module load_queue_tb
    import lq_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    // six tests use a few hundred cycles
    localparam int WATCHDOG_CYCLES = 4000;

    logic        clk;
    logic        rst;
    logic        dis_en_i;
    rob_idx_t    dis_rob_idx_i;
    lq_idx_t     lq_idx_o;
    logic        full_o;
    logic        issue_en_i;
    lq_ptr_t     issue_lq_idx_i;
    logic        issue_miss_i;
    reg_idx_t    issue_rd_i;
    paddr_t      issue_addr_i;
    byte_mask_t  issue_mask_i;
    byte_mask_t  issue_fwd_mask_i;
    data_t       issue_fwd_data_i;
    logic        refill_en_i;
    lq_ptr_t     refill_lq_idx_i;
    data_t       refill_data_i;
    logic        wb_valid_o;
    logic        wb_ready_i;
    rob_idx_t    wb_rob_idx_o;
    reg_idx_t    wb_rd_o;
    data_t       wb_data_o;
    commit_cnt_t commit_num_i;
    logic        st_en_i;
    lq_idx_t     st_lq_idx_i;
    paddr_t      st_addr_i;
    byte_mask_t  st_mask_i;
    logic        vio_valid_o;
    lq_idx_t     vio_lq_idx_o;
    rob_idx_t    vio_rob_idx_o;

    int       errors;
    lq_idx_t  exp_tail;
    rob_idx_t exp_tag  [`LQ_DEPTH];
    reg_idx_t exp_rd   [`LQ_DEPTH];
    data_t    exp_data [`LQ_DEPTH];

    tb_clock_gen u_clock_gen (.clk(clk));

    load_queue u_load_queue (.*);

    bind load_queue load_queue_assert u_load_queue_assert (.*);

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_lq_idx(input lq_idx_t got, input lq_idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rob(input rob_idx_t got, input rob_idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // forwarded bytes take priority over refill bytes
    function automatic data_t merge_bytes(input byte_mask_t fmask, input data_t fdata,
                                          input data_t rdata);
        data_t res;
        for (int b = 0; b < `BYTE_N; b++) begin
            res[b*8 +: 8] = fmask[b] ? fdata[b*8 +: 8] : rdata[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic dispatch(input rob_idx_t tag);
        @(posedge clk);
        dis_en_i      <= 1'b1;
        dis_rob_idx_i <= tag;
        @(posedge clk);
        dis_en_i      <= 1'b0;
    endtask

    task automatic issue_load(input lq_ptr_t ptr, input logic miss, input reg_idx_t rd,
                              input paddr_t addr, input byte_mask_t mask,
                              input byte_mask_t fmask, input data_t fdata);
        @(posedge clk);
        issue_en_i       <= 1'b1;
        issue_lq_idx_i   <= ptr;
        issue_miss_i     <= miss;
        issue_rd_i       <= rd;
        issue_addr_i     <= addr;
        issue_mask_i     <= mask;
        issue_fwd_mask_i <= fmask;
        issue_fwd_data_i <= fdata;
        @(posedge clk);
        issue_en_i       <= 1'b0;
    endtask

    task automatic refill(input lq_ptr_t ptr, input data_t data);
        @(posedge clk);
        refill_en_i     <= 1'b1;
        refill_lq_idx_i <= ptr;
        refill_data_i   <= data;
        @(posedge clk);
        refill_en_i     <= 1'b0;
    endtask

    task automatic commit_loads(input commit_cnt_t n);
        @(posedge clk);
        commit_num_i <= n;
        @(posedge clk);
        commit_num_i <= '0;
    endtask

    // expects entries first .. first+count-1 in that order
    task automatic drain_writeback(input int first, input int count);
        int seen;
        seen = 0;
        @(posedge clk);
        wb_ready_i <= 1'b1;
        for (int n = 0; n < count + 4; n++) begin
            @(negedge clk);
            if (!wb_valid_o) begin
                break;
            end
            if (seen < count) begin
                check_rob(wb_rob_idx_o, exp_tag[first + seen], "returned tag");
                check_rd(wb_rd_o, exp_rd[first + seen], "returned register");
                check_data(wb_data_o, exp_data[first + seen], "returned data");
            end
            seen++;
            @(posedge clk);
        end
        @(posedge clk);
        wb_ready_i <= 1'b0;
        if (seen != count) begin
            errors++;
            $display("CHECK FAILED at %0t: writeback returned %0d loads while %0d were pending",
                     $time, seen, count);
        end
    endtask

    task automatic store_check(input lq_idx_t idx, input paddr_t addr, input byte_mask_t mask,
                               input logic exp_hit, input lq_idx_t exp_idx,
                               input rob_idx_t exp_rob);
        @(posedge clk);
        st_en_i     <= 1'b1;
        st_lq_idx_i <= idx;
        st_addr_i   <= addr;
        st_mask_i   <= mask;
        @(negedge clk);
        check_flag(vio_valid_o, 1'b0, "violation in the store cycle");
        @(posedge clk);
        st_en_i     <= 1'b0;
        @(negedge clk);
        check_flag(vio_valid_o, exp_hit, "violation one cycle after store");
        if (exp_hit) begin
            check_lq_idx(vio_lq_idx_o, exp_idx, "violating load index");
            check_rob(vio_rob_idx_o, exp_rob, "violating load tag");
        end
    endtask

    task automatic reset_and_allocate();
        rob_idx_t tag;
        @(negedge clk);
        check_flag(full_o, 1'b0, "full after reset");
        check_flag(wb_valid_o, 1'b0, "wb_valid after reset");
        check_flag(vio_valid_o, 1'b0, "vio_valid after reset");
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            check_lq_idx(lq_idx_o, exp_tail, "allocation index");
            tag = rob_idx_t'($urandom);
            exp_tag[exp_tail[`LQ_IDX_W-1:0]] = tag;
            dispatch(tag);
            exp_tail = exp_tail + 1'b1;
            @(negedge clk);
        end
        check_flag(full_o, 1'b1, "full after sixteen dispatches");
        dispatch(rob_idx_t'($urandom));
        @(negedge clk);
        check_lq_idx(lq_idx_o, exp_tail, "index after dispatch while full");
        check_flag(full_o, 1'b1, "full after dispatch while full");
    endtask

    task automatic miss_refill_merge();
        data_t fwd;
        data_t fill;
        fwd       = data_t'($urandom);
        fill      = data_t'($urandom);
        exp_rd[0] = reg_idx_t'($urandom);
        issue_load(lq_ptr_t'(0), 1'b1, exp_rd[0], paddr_t'($urandom), 4'b1111, 4'b0101, fwd);
        @(negedge clk);
        check_flag(wb_valid_o, 1'b0, "wb_valid before refill");
        exp_data[0] = merge_bytes(4'b0101, fwd, fill);
        refill(lq_ptr_t'(0), fill);
        @(negedge clk);
        check_flag(wb_valid_o, 1'b1, "wb_valid after refill");
        drain_writeback(0, 1);
    endtask

    task automatic writeback_back_pressure();
        data_t      fwd;
        data_t      fill [4];
        byte_mask_t fmask;
        for (int i = 1; i <= 3; i++) begin
            fwd         = data_t'($urandom);
            fill[i]     = data_t'($urandom);
            fmask       = byte_mask_t'($urandom);
            exp_rd[i]   = reg_idx_t'($urandom);
            exp_data[i] = merge_bytes(fmask, fwd, fill[i]);
            issue_load(lq_ptr_t'(i), 1'b1, exp_rd[i], paddr_t'($urandom), 4'b1111, fmask, fwd);
        end
        refill(lq_ptr_t'(3), fill[3]);
        @(negedge clk);
        check_rob(wb_rob_idx_o, exp_tag[3], "presented entry after first refill");
        refill(lq_ptr_t'(1), fill[1]);
        refill(lq_ptr_t'(2), fill[2]);
        repeat (3) begin
            @(negedge clk);
            check_flag(wb_valid_o, 1'b1, "wb_valid under back-pressure");
            check_rob(wb_rob_idx_o, exp_tag[1], "presented entry under back-pressure");
        end
        drain_writeback(1, 3);
    endtask

    task automatic hit_loads_skip_writeback();
        for (int i = 4; i < 8; i++) begin
            issue_load(lq_ptr_t'(i), 1'b0, reg_idx_t'($urandom), paddr_t'($urandom),
                       4'b1111, 4'b0000, '0);
            @(negedge clk);
            check_flag(wb_valid_o, 1'b0, "hit load on writeback");
        end
        refill(lq_ptr_t'(4), data_t'($urandom));
        @(negedge clk);
        check_flag(wb_valid_o, 1'b0, "refill of a hit load");
    endtask

    task automatic wrap_after_commit();
        rob_idx_t tag;
        commit_loads(2);
        @(negedge clk);
        check_flag(full_o, 1'b0, "full after commit of two");
        check_lq_idx(lq_idx_o, exp_tail, "tail after commit");
        commit_loads(1);
        @(negedge clk);
        check_flag(full_o, 1'b0, "full after commit of one");
        commit_loads(0);
        @(negedge clk);
        check_flag(full_o, 1'b0, "full after commit of zero");
        // freed entries come back with the direction bit set
        for (int i = 0; i < 3; i++) begin
            check_lq_idx(lq_idx_o, exp_tail, "index after wrap");
            tag = rob_idx_t'($urandom);
            exp_tag[exp_tail[`LQ_IDX_W-1:0]] = tag;
            dispatch(tag);
            exp_tail = exp_tail + 1'b1;
            @(negedge clk);
        end
        check_flag(full_o, 1'b1, "full after wrapped dispatches");
    endtask

    task automatic ordering_violation();
        paddr_t base;
        base = paddr_t'($urandom) & ~paddr_t'(3);
        // head sits at entry 3 and the store goes at entry 8
        issue_load(lq_ptr_t'(9), 1'b0, reg_idx_t'($urandom), base, 4'b0011, 4'b0000, '0);
        issue_load(lq_ptr_t'(10), 1'b0, reg_idx_t'($urandom), base + 1, 4'b0110, 4'b0000, '0);
        store_check(5'h08, base + 2, 4'b0010, 1'b1, 5'h09, exp_tag[9]);
        store_check(5'h08, base, 4'b1000, 1'b0, '0, '0);
        store_check(5'h08, base + 4, 4'b1111, 1'b0, '0, '0);
        store_check(5'h12, base, 4'b1111, 1'b0, '0, '0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(32'h291a708d));
        errors           = 0;
        exp_tail         = '0;
        rst              <= 1'b1;
        dis_en_i         <= 1'b0;
        dis_rob_idx_i    <= '0;
        issue_en_i       <= 1'b0;
        issue_lq_idx_i   <= '0;
        issue_miss_i     <= 1'b0;
        issue_rd_i       <= '0;
        issue_addr_i     <= '0;
        issue_mask_i     <= '0;
        issue_fwd_mask_i <= '0;
        issue_fwd_data_i <= '0;
        refill_en_i      <= 1'b0;
        refill_lq_idx_i  <= '0;
        refill_data_i    <= '0;
        wb_ready_i       <= 1'b0;
        commit_num_i     <= '0;
        st_en_i          <= 1'b0;
        st_lq_idx_i      <= '0;
        st_addr_i        <= '0;
        st_mask_i        <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        reset_and_allocate();
        miss_refill_merge();
        writeback_back_pressure();
        hit_loads_skip_writeback();
        wrap_after_commit();
        ordering_violation();

        repeat (2) @(posedge clk);
        total = errors + u_load_queue.u_load_queue_assert.fail_count;
        $display("summary: %0d check errors, %0d assertion failures", errors,
                 u_load_queue.u_load_queue_assert.fail_count);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- load_queue_assert.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue_assert
    import lq_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    dis_en_i,
    input logic    full_o,
    input lq_idx_t lq_idx_o,
    input logic    wb_valid_o,
    input logic    st_en_i,
    input logic    vio_valid_o
);

    int fail_count = 0;

    // tail holds when dispatch meets a full queue
    dispatch_while_full: assert property (@(posedge clk) disable iff (rst)
        (dis_en_i && full_o) |=> $stable(lq_idx_o))
    else begin
        fail_count++;
        $error("tail moved on a dispatch while the queue was full");
    end

    wb_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(wb_valid_o))
    else begin
        fail_count++;
        $error("wb_valid_o is unknown");
    end

    // report only follows a store strobe
    vio_needs_store: assert property (@(posedge clk) disable iff (rst)
        !st_en_i |=> !vio_valid_o)
    else begin
        fail_count++;
        $error("violation reported without a store in the previous cycle");
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- load_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lq_config.svh"

module load_queue
    import lq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        dis_en_i,
    input  rob_idx_t    dis_rob_idx_i,
    output lq_idx_t     lq_idx_o,
    output logic        full_o,

    input  logic        issue_en_i,
    input  lq_ptr_t     issue_lq_idx_i,
    input  logic        issue_miss_i,
    input  reg_idx_t    issue_rd_i,
    input  paddr_t      issue_addr_i,
    input  byte_mask_t  issue_mask_i,
    input  byte_mask_t  issue_fwd_mask_i,
    input  data_t       issue_fwd_data_i,

    input  logic        refill_en_i,
    input  lq_ptr_t     refill_lq_idx_i,
    input  data_t       refill_data_i,

    output logic        wb_valid_o,
    input  logic        wb_ready_i,
    output rob_idx_t    wb_rob_idx_o,
    output reg_idx_t    wb_rd_o,
    output data_t       wb_data_o,

    input  commit_cnt_t commit_num_i,

    input  logic        st_en_i,
    input  lq_idx_t     st_lq_idx_i,
    input  paddr_t      st_addr_i,
    input  byte_mask_t  st_mask_i,

    output logic        vio_valid_o,
    output lq_idx_t     vio_lq_idx_o,
    output rob_idx_t    vio_rob_idx_o
);

    lq_idx_t                  head;
    lq_idx_t                  tail;
    logic                     full;
    logic [`LQ_DEPTH-1:0]     entry_valid;
    rob_idx_t [`LQ_DEPTH-1:0] rob_tags;

    lq_issue_if issue_bus ();

    assign issue_bus.en       = issue_en_i;
    assign issue_bus.lq_idx   = issue_lq_idx_i;
    assign issue_bus.miss     = issue_miss_i;
    assign issue_bus.rd       = issue_rd_i;
    assign issue_bus.addr     = issue_addr_i;
    assign issue_bus.mask     = issue_mask_i;
    assign issue_bus.fwd_mask = issue_fwd_mask_i;
    assign issue_bus.fwd_data = issue_fwd_data_i;

    lq_pointers u_pointers (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en_i),
        .commit_num_i (commit_num_i),
        .head_o       (head),
        .tail_o       (tail),
        .full_o       (full)
    );

    lq_entry_table u_entry_table (
        .clk             (clk),
        .rst             (rst),
        .issue           (issue_bus.tbl),
        .dis_en_i        (dis_en_i),
        .dis_rob_idx_i   (dis_rob_idx_i),
        .refill_en_i     (refill_en_i),
        .refill_lq_idx_i (refill_lq_idx_i),
        .refill_data_i   (refill_data_i),
        .wb_ready_i      (wb_ready_i),
        .commit_num_i    (commit_num_i),
        .tail_i          (tail),
        .head_i          (head),
        .full_i          (full),
        .entry_valid_o   (entry_valid),
        .wb_valid_o      (wb_valid_o),
        .wb_rob_idx_o    (wb_rob_idx_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .rob_tags_o      (rob_tags)
    );

    lq_violation_check u_violation_check (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue_bus.check),
        .entry_valid_i (entry_valid),
        .head_i        (head),
        .tail_i        (tail),
        .st_en_i       (st_en_i),
        .st_lq_idx_i   (st_lq_idx_i),
        .st_addr_i     (st_addr_i),
        .st_mask_i     (st_mask_i),
        .rob_tags_i    (rob_tags),
        .vio_valid_o   (vio_valid_o),
        .vio_lq_idx_o  (vio_lq_idx_o),
        .vio_rob_idx_o (vio_rob_idx_o)
    );

    // tail is the next free entry
    assign lq_idx_o = tail;
    assign full_o   = full;

endmodule

`default_nettype wire

//--- lq_violation_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "lq_config.svh"

module lq_violation_check
    import lq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    lq_issue_if.check                issue,
    input  logic [`LQ_DEPTH-1:0]     entry_valid_i,
    input  lq_idx_t                  head_i,
    input  lq_idx_t                  tail_i,
    input  logic                     st_en_i,
    input  lq_idx_t                  st_lq_idx_i,
    input  paddr_t                   st_addr_i,
    input  byte_mask_t               st_mask_i,
    input  rob_idx_t [`LQ_DEPTH-1:0] rob_tags_i,
    output logic                     vio_valid_o,
    output lq_idx_t                  vio_lq_idx_o,
    output rob_idx_t                 vio_rob_idx_o
);

    logic [`PADDR_W-1:`BYTE_OFF_W] word_addr_q [`LQ_DEPTH];
    byte_mask_t                    mask_q      [`LQ_DEPTH];

    logic [`LQ_DEPTH-1:0] known_q;
    logic [`LQ_DEPTH-1:0] younger;
    logic [`LQ_DEPTH-1:0] overlap;
    logic [`LQ_DEPTH-1:0] hit;

    lq_idx_t  occupancy;
    lq_idx_t  st_dist;
    logic     st_in_range;
    logic     sel_found;
    lq_ptr_t  sel_dist;
    lq_ptr_t  sel_ptr;
    logic     vio_valid_q;
    lq_idx_t  vio_idx_q;
    rob_idx_t vio_rob_q;

    // address known from issue until the entry is freed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            known_q <= '0;
        end else begin
            known_q <= known_q & entry_valid_i;
            if (issue.en) begin
                known_q[issue.lq_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.en) begin
            word_addr_q[issue.lq_idx] <= issue.addr[`PADDR_W-1:`BYTE_OFF_W];
            mask_q[issue.lq_idx]      <= issue.mask;
        end
    end

    // distances from head with the direction bit included
    assign occupancy   = tail_i - head_i;
    assign st_dist     = st_lq_idx_i - head_i;
    assign st_in_range = (st_dist <= occupancy);

    for (genvar i = 0; i < `LQ_DEPTH; i++) begin : g_cmp
        lq_ptr_t ld_dist;
        assign ld_dist    = lq_ptr_t'(i) - head_i[`LQ_IDX_W-1:0];
        assign younger[i] = ({1'b0, ld_dist} >= st_dist);
        assign overlap[i] = (word_addr_q[i] == st_addr_i[`PADDR_W-1:`BYTE_OFF_W])
                          & (|(mask_q[i] & st_mask_i));
    end

    assign hit = {`LQ_DEPTH{st_en_i & st_in_range}} & entry_valid_i & known_q
               & younger & overlap;

    // walk in queue order so the first hit is the oldest
    always_comb begin
        lq_ptr_t p;
        sel_found = 1'b0;
        sel_dist  = '0;
        for (int k = 0; k < `LQ_DEPTH; k++) begin
            p = head_i[`LQ_IDX_W-1:0] + lq_ptr_t'(k);
            if (!sel_found && hit[p]) begin
                sel_found = 1'b1;
                sel_dist  = lq_ptr_t'(k);
            end
        end
    end

    assign sel_ptr = head_i[`LQ_IDX_W-1:0] + sel_dist;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vio_valid_q <= 1'b0;
        end else begin
            vio_valid_q <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_found) begin
            vio_idx_q <= head_i + lq_idx_t'(sel_dist);
            vio_rob_q <= rob_tags_i[sel_ptr];
        end
    end

    assign vio_valid_o   = vio_valid_q;
    assign vio_lq_idx_o  = vio_idx_q;
    assign vio_rob_idx_o = vio_rob_q;

endmodule

`default_nettype wire

//--- lq_entry_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "lq_config.svh"

module lq_entry_table
    import lq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    lq_issue_if.tbl                  issue,
    input  logic                     dis_en_i,
    input  rob_idx_t                 dis_rob_idx_i,
    input  logic                     refill_en_i,
    input  lq_ptr_t                  refill_lq_idx_i,
    input  data_t                    refill_data_i,
    input  logic                     wb_ready_i,
    input  commit_cnt_t              commit_num_i,
    input  lq_idx_t                  tail_i,
    input  lq_idx_t                  head_i,
    input  logic                     full_i,
    output logic [`LQ_DEPTH-1:0]     entry_valid_o,
    output logic                     wb_valid_o,
    output rob_idx_t                 wb_rob_idx_o,
    output reg_idx_t                 wb_rd_o,
    output data_t                    wb_data_o,
    output rob_idx_t [`LQ_DEPTH-1:0] rob_tags_o
);

    localparam int BYTE_W = `DATA_W / `BYTE_N;

    logic [`LQ_DEPTH-1:0] valid_q;
    logic [`LQ_DEPTH-1:0] addr_valid_q;
    logic [`LQ_DEPTH-1:0] miss_q;
    logic [`LQ_DEPTH-1:0] data_valid_q;
    logic [`LQ_DEPTH-1:0] returned_q;
    logic [`LQ_DEPTH-1:0] waiting;
    logic [`LQ_DEPTH-1:0] commit_clr;

    rob_idx_t [`LQ_DEPTH-1:0] rob_tag_q;
    reg_idx_t   rd_q        [`LQ_DEPTH];
    byte_mask_t fwd_mask_q  [`LQ_DEPTH];
    data_t      fwd_data_q  [`LQ_DEPTH];
    data_t      load_data_q [`LQ_DEPTH];

    lq_ptr_t tail_ptr;
    lq_ptr_t wb_idx;
    logic    dis_accept;
    logic    refill_ok;
    logic    wb_fire;
    data_t   refill_merged;

    assign tail_ptr   = tail_i[`LQ_IDX_W-1:0];
    assign dis_accept = dis_en_i & ~full_i;

    // only an outstanding miss takes refill data
    assign refill_ok = refill_en_i & valid_q[refill_lq_idx_i] & miss_q[refill_lq_idx_i]
                     & ~data_valid_q[refill_lq_idx_i];

    // forwarded store bytes win over the cache line
    always_comb begin
        for (int b = 0; b < `BYTE_N; b++) begin
            if (fwd_mask_q[refill_lq_idx_i][b]) begin
                refill_merged[b*BYTE_W +: BYTE_W] = fwd_data_q[refill_lq_idx_i][b*BYTE_W +: BYTE_W];
            end else begin
                refill_merged[b*BYTE_W +: BYTE_W] = refill_data_i[b*BYTE_W +: BYTE_W];
            end
        end
    end

    // free up to COMMIT_W entries from the head
    always_comb begin
        lq_ptr_t ptr;
        commit_clr = '0;
        for (int i = 0; i < `COMMIT_W; i++) begin
            ptr = head_i[`LQ_IDX_W-1:0] + lq_ptr_t'(i);
            if (commit_cnt_t'(i) < commit_num_i) begin
                commit_clr[ptr] = 1'b1;
            end
        end
    end

    assign waiting = valid_q & addr_valid_q & miss_q & data_valid_q & ~returned_q;

    // lowest numbered pending miss
    always_comb begin
        wb_idx = '0;
        for (int i = `LQ_DEPTH - 1; i >= 0; i--) begin
            if (waiting[i]) begin
                wb_idx = lq_ptr_t'(i);
            end
        end
    end

    assign wb_valid_o = |waiting;
    assign wb_fire    = wb_valid_o & wb_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q      <= '0;
            addr_valid_q <= '0;
            miss_q       <= '0;
            data_valid_q <= '0;
            returned_q   <= '0;
        end else begin
            valid_q <= valid_q & ~commit_clr;
            if (dis_accept) begin
                valid_q[tail_ptr]      <= 1'b1;
                addr_valid_q[tail_ptr] <= 1'b0;
                miss_q[tail_ptr]       <= 1'b0;
                data_valid_q[tail_ptr] <= 1'b0;
                returned_q[tail_ptr]   <= 1'b0;
            end
            if (issue.en) begin
                addr_valid_q[issue.lq_idx] <= 1'b1;
                miss_q[issue.lq_idx]       <= issue.miss;
                // a hit is complete at issue
                data_valid_q[issue.lq_idx] <= ~issue.miss;
                returned_q[issue.lq_idx]   <= ~issue.miss;
            end
            if (refill_ok) begin
                data_valid_q[refill_lq_idx_i] <= 1'b1;
            end
            if (wb_fire) begin
                returned_q[wb_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dis_accept) begin
            rob_tag_q[tail_ptr] <= dis_rob_idx_i;
        end
        if (issue.en) begin
            rd_q[issue.lq_idx]       <= issue.rd;
            fwd_mask_q[issue.lq_idx] <= issue.fwd_mask;
            fwd_data_q[issue.lq_idx] <= issue.fwd_data;
        end
        if (refill_ok) begin
            load_data_q[refill_lq_idx_i] <= refill_merged;
        end
    end

    assign wb_rob_idx_o  = rob_tag_q[wb_idx];
    assign wb_rd_o       = rd_q[wb_idx];
    assign wb_data_o     = load_data_q[wb_idx];
    assign entry_valid_o = valid_q;
    assign rob_tags_o    = rob_tag_q;

endmodule

`default_nettype wire

//--- lq_pointers.sv
`timescale 1ns/1ps
`default_nettype none
`include "lq_config.svh"

module lq_pointers
    import lq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        dis_en_i,
    input  commit_cnt_t commit_num_i,
    output lq_idx_t     head_o,
    output lq_idx_t     tail_o,
    output logic        full_o
);

    lq_idx_t head_q;
    lq_idx_t tail_q;
    lq_idx_t occupancy;
    logic    dis_accept;

    // depth is a power of two, so the carry into the top bit
    // flips the direction on every wrap
    assign occupancy = tail_q - head_q;

    // same index with the other direction
    assign full_o = (occupancy == lq_idx_t'(`LQ_DEPTH));

    assign dis_accept = dis_en_i & ~full_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + lq_idx_t'(commit_num_i);
            if (dis_accept) begin
                tail_q <= tail_q + lq_idx_t'(1);
            end
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

`default_nettype wire

//--- lq_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lq_issue_if import lq_pkg::*; ();

    logic       en;
    lq_ptr_t    lq_idx;
    logic       miss;
    reg_idx_t   rd;
    paddr_t     addr;
    byte_mask_t mask;
    byte_mask_t fwd_mask;
    data_t      fwd_data;

    modport src (output en, lq_idx, miss, rd, addr, mask, fwd_mask, fwd_data);

    // entry table keeps status, register and forwarded bytes
    modport tbl (input en, lq_idx, miss, rd, fwd_mask, fwd_data);

    modport check (input en, lq_idx, addr, mask);

endinterface

`default_nettype wire

//--- lq_pkg.sv
`default_nettype none
`include "lq_config.svh"

package lq_pkg;

    // entry index with the wrap direction in the top bit
    typedef logic [`LQ_IDX_W:0]               lq_idx_t;
    typedef logic [`LQ_IDX_W-1:0]             lq_ptr_t;

    // rob tag is only carried along
    typedef logic [`ROB_IDX_W-1:0]            rob_idx_t;
    typedef logic [`REG_IDX_W-1:0]            reg_idx_t;

    typedef logic [`PADDR_W-1:0]              paddr_t;
    typedef logic [`DATA_W-1:0]               data_t;
    typedef logic [`BYTE_N-1:0]               byte_mask_t;

    // 0 up to COMMIT_W
    typedef logic [$clog2(`COMMIT_W+1)-1:0]   commit_cnt_t;

endpackage

`default_nettype wire

//--- lq_config.svh
`ifndef LQ_CONFIG_SVH
`define LQ_CONFIG_SVH

// queue geometry
`define LQ_DEPTH    16
`define LQ_IDX_W    4

// tag and register widths
`define ROB_IDX_W   6
`define REG_IDX_W   5

// memory side
`define PADDR_W     32
`define DATA_W      32
`define BYTE_N      4
`define BYTE_OFF_W  2

// loads freed per cycle at most
`define COMMIT_W    2

`endif
